/* Bender.yml */
package:
  name: id_operand_unit

sources:
  - common/core_pkg.sv
  - verilog/rf32x32.sv
  - forward/data_forward_u.sv
  - verilog/id_data_picker.sv
  - verilog/id_operand_unit.sv
  - target: simulation
    files:
      - tests/tb_id_operand_unit.sv

/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

    // RV32I operand geometry
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Class of the instruction sitting in a later stage
    typedef enum logic [2:0] {
        OPC_ALU    = 3'd0,
        OPC_LOAD   = 3'd1,
        OPC_STORE  = 3'd2,
        OPC_BRANCH = 3'd3,
        OPC_JUMP   = 3'd4,
        OPC_CSR    = 3'd5
    } op_class_e;

    // Where an operand is taken from
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_e;

    // Decode-stage source operands
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  use_rs1;
        logic                  use_rs2;
    } id_src_t;

    // Destination of an instruction in EX or MEM
    typedef struct packed {
        logic                  wr_reg_n;
        logic [REG_ADDR_W-1:0] rd;
        op_class_e             op;
        logic [XLEN-1:0]       fwd_data;
    } stage_dst_t;

    // Write-back port into the register file
    typedef struct packed {
        logic                  wr_n;
        logic [REG_ADDR_W-1:0] wr_addr;
        logic [XLEN-1:0]       data;
    } wb_write_t;

    // Operand source selects
    typedef struct packed {
        fwd_sel_e sel1;
        fwd_sel_e sel2;
    } fwd_ctrl_t;

endpackage

`default_nettype wire

/* forward/data_forward_u.sv */
`default_nettype none

module data_forward_u (
    input  core_pkg::id_src_t    i_id,
    input  core_pkg::stage_dst_t i_ex,
    input  core_pkg::stage_dst_t i_mem,
    output core_pkg::fwd_ctrl_t  o_fwd,
    output logic                 o_stall
);

    import core_pkg::*;

    logic ex_writes;
    logic mem_writes;
    logic ex_is_load;
    logic load_hit1;
    logic load_hit2;

    assign ex_writes  = !i_ex.wr_reg_n;
    assign mem_writes = !i_mem.wr_reg_n;
    assign ex_is_load = (i_ex.op == OPC_LOAD);

    // A source that can take a forwarded value at all
    function automatic logic src_live(
        input logic [REG_ADDR_W-1:0] src,
        input logic                  use_src
    );
        return use_src && (src != '0);
    endfunction

    // EX first, then MEM, then the register file
    function automatic fwd_sel_e pick_source(
        input logic [REG_ADDR_W-1:0] src,
        input logic                  use_src,
        input logic                  ex_wr,
        input logic                  ex_load,
        input logic [REG_ADDR_W-1:0] ex_rd,
        input logic                  mem_wr,
        input logic [REG_ADDR_W-1:0] mem_rd
    );
        fwd_sel_e sel;
        if (!src_live(src, use_src)) begin
            sel = FWD_RF;
        end else if (ex_wr && !ex_load && (ex_rd == src)) begin
            sel = FWD_EX;
        end else if (mem_wr && (mem_rd == src)) begin
            // Load data is already in the MEM forward value
            sel = FWD_MEM;
        end else begin
            sel = FWD_RF;
        end
        return sel;
    endfunction

    always_comb begin
        o_fwd.sel1 = pick_source(i_id.rs1, i_id.use_rs1, ex_writes, ex_is_load,
                                 i_ex.rd, mem_writes, i_mem.rd);
        o_fwd.sel2 = pick_source(i_id.rs2, i_id.use_rs2, ex_writes, ex_is_load,
                                 i_ex.rd, mem_writes, i_mem.rd);
    end

    // Load in EX whose result decode needs now
    assign load_hit1 = src_live(i_id.rs1, i_id.use_rs1) && (i_ex.rd == i_id.rs1);
    assign load_hit2 = src_live(i_id.rs2, i_id.use_rs2) && (i_ex.rd == i_id.rs2);

    assign o_stall = ex_writes && ex_is_load && (load_hit1 || load_hit2);

endmodule

`default_nettype wire

/* tests/tb_id_operand_unit.sv */
`default_nettype none

module tb_id_operand_unit;

    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    typedef struct packed {
        logic [XLEN-1:0] data1;
        logic [XLEN-1:0] data2;
        logic            stall;
    } expect_t;

    localparam int RESET_CYCLES    = 16;
    localparam int RANDOM_CYCLES   = 2000;
    // Reset, directed and random phases plus some margin
    localparam int TIMEOUT_CYCLES  = 2500;

    logic            clk;
    logic            i_rst_n;
    id_src_t         i_id;
    stage_dst_t      i_ex;
    stage_dst_t      i_mem;
    wb_write_t       i_wb;
    logic [XLEN-1:0] o_data1;
    logic [XLEN-1:0] o_data2;
    logic            o_stall;

    logic [XLEN-1:0] ref_regs [0:NUM_REGS-1];
    logic            checking;
    int              error_count;
    int              check_count;
    int              cycle_count;

    id_operand_unit UUT (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_id    (i_id),
        .i_ex    (i_ex),
        .i_mem   (i_mem),
        .i_wb    (i_wb),
        .o_data1 (o_data1),
        .o_data2 (o_data2),
        .o_stall (o_stall)
    );

    always #4 clk = ~clk;

    function automatic id_src_t make_src(input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic u1, input logic u2);
        id_src_t s;
        s.rs1     = rs1;
        s.rs2     = rs2;
        s.use_rs1 = u1;
        s.use_rs2 = u2;
        return s;
    endfunction

    function automatic stage_dst_t make_stage(input logic wr_n, input logic [4:0] rd,
                                              input op_class_e op, input logic [31:0] data);
        stage_dst_t s;
        s.wr_reg_n = wr_n;
        s.rd       = rd;
        s.op       = op;
        s.fwd_data = data;
        return s;
    endfunction

    function automatic wb_write_t make_wb(input logic wr_n, input logic [4:0] addr,
                                          input logic [31:0] data);
        wb_write_t w;
        w.wr_n    = wr_n;
        w.wr_addr = addr;
        w.data    = data;
        return w;
    endfunction

    // Value one source should see, stage by stage in priority order
    function automatic logic [XLEN-1:0] operand_value(input logic [4:0] addr, input logic used,
                                                      input stage_dst_t ex,
                                                      input stage_dst_t mem,
                                                      input wb_write_t wb);
        logic [XLEN-1:0] val;
        if (addr == 5'd0) begin
            val = '0;
        end else if (used && !ex.wr_reg_n && ex.op != OPC_LOAD && ex.rd == addr) begin
            val = ex.fwd_data;
        end else if (used && !mem.wr_reg_n && mem.rd == addr) begin
            val = mem.fwd_data;
        end else if (!wb.wr_n && wb.wr_addr == addr) begin
            val = wb.data;
        end else begin
            val = ref_regs[addr];
        end
        return val;
    endfunction

    function automatic expect_t compute_expected(input id_src_t id, input stage_dst_t ex,
                                                 input stage_dst_t mem, input wb_write_t wb);
        expect_t e;
        logic    hit1;
        logic    hit2;
        e.data1 = operand_value(id.rs1, id.use_rs1, ex, mem, wb);
        e.data2 = operand_value(id.rs2, id.use_rs2, ex, mem, wb);
        hit1    = id.use_rs1 && (id.rs1 != 5'd0) && (ex.rd == id.rs1);
        hit2    = id.use_rs2 && (id.rs2 != 5'd0) && (ex.rd == id.rs2);
        e.stall = !ex.wr_reg_n && (ex.op == OPC_LOAD) && (hit1 || hit2);
        return e;
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [4:0] random_reg();
        // Mostly x0..x3 so that address matches are frequent
        if ($urandom % 4 != 0) begin
            return 5'($urandom % 4);
        end
        return 5'($urandom % 32);
    endfunction

    // Register file model
    always @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                ref_regs[i] <= '0;
            end
        end else if (!i_wb.wr_n && i_wb.wr_addr != 5'd0) begin
            ref_regs[i_wb.wr_addr] <= i_wb.data;
        end
    end

    // Sample 1 ns before each rising edge
    always begin
        expect_t exp_val;
        @(negedge clk);
        #3;
        if (checking) begin
            exp_val = compute_expected(i_id, i_ex, i_mem, i_wb);
            check_value("o_data1", o_data1, exp_val.data1);
            check_value("o_data2", o_data2, exp_val.data2);
            check_value("o_stall", XLEN'(o_stall), XLEN'(exp_val.stall));
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles with %0d errors", cycle_count, error_count);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(84933));
        clk         = 1'b0;
        i_rst_n     = 1'b0;
        checking    = 1'b0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        i_id        = make_src(5'd0, 5'd0, 1'b0, 1'b0);
        i_ex        = make_stage(1'b1, 5'd0, OPC_ALU, '0);
        i_mem       = make_stage(1'b1, 5'd0, OPC_ALU, '0);
        i_wb        = make_wb(1'b1, 5'd0, '0);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        i_rst_n  = 1'b1;
        checking = 1'b1;

        // Every register reads zero on both ports while idle stages carry junk
        for (int k = 0; k < NUM_REGS; k++) begin
            i_id  = make_src(5'(k), 5'(NUM_REGS - 1 - k), 1'b1, 1'b1);
            i_ex  = make_stage(1'b1, 5'(k), OPC_LOAD, $urandom);
            i_mem = make_stage(1'b1, 5'(NUM_REGS - 1 - k), OPC_ALU, $urandom);
            step();
        end

        // Write-back, same-cycle bypass and x0
        i_ex  = make_stage(1'b1, 5'd0, OPC_ALU, 32'h1111_1111);
        i_mem = make_stage(1'b1, 5'd0, OPC_ALU, 32'h2222_2222);
        i_wb  = make_wb(1'b0, 5'd5, 32'hA5A5_0005);
        i_id  = make_src(5'd5, 5'd6, 1'b1, 1'b1);
        step();
        i_wb = make_wb(1'b1, 5'd5, 32'h0);
        i_id = make_src(5'd5, 5'd5, 1'b1, 1'b1);
        step();
        i_wb = make_wb(1'b0, 5'd0, 32'hFFFF_FFFF);
        i_id = make_src(5'd0, 5'd0, 1'b1, 1'b1);
        step();
        i_wb = make_wb(1'b0, 5'd7, 32'hB7B7_0007);
        step();
        i_wb = make_wb(1'b1, 5'd0, 32'h0);
        i_id = make_src(5'd7, 5'd0, 1'b1, 1'b1);
        step();

        // EX beats MEM, MEM alone, each operand on its own
        i_ex  = make_stage(1'b0, 5'd5, OPC_ALU, 32'hE000_0001);
        i_mem = make_stage(1'b0, 5'd5, OPC_ALU, 32'hD000_0001);
        i_id  = make_src(5'd5, 5'd5, 1'b1, 1'b1);
        step();
        i_ex = make_stage(1'b0, 5'd6, OPC_ALU, 32'hE000_0002);
        i_id = make_src(5'd5, 5'd7, 1'b1, 1'b1);
        step();
        i_id = make_src(5'd7, 5'd5, 1'b1, 1'b1);
        step();
        i_id = make_src(5'd6, 5'd5, 1'b1, 1'b1);
        step();

        // Load-use stall in EX, load data forwarded from MEM
        i_mem = make_stage(1'b1, 5'd0, OPC_ALU, 32'h0);
        i_ex  = make_stage(1'b0, 5'd5, OPC_LOAD, 32'hE000_0003);
        i_id  = make_src(5'd5, 5'd0, 1'b1, 1'b1);
        step();
        i_ex = make_stage(1'b0, 5'd7, OPC_LOAD, 32'hE000_0004);
        i_id = make_src(5'd1, 5'd7, 1'b1, 1'b1);
        step();
        i_ex = make_stage(1'b0, 5'd5, OPC_LOAD, 32'hE000_0005);
        i_id = make_src(5'd5, 5'd5, 1'b0, 1'b0);
        step();
        i_ex  = make_stage(1'b1, 5'd0, OPC_ALU, 32'h0);
        i_mem = make_stage(1'b0, 5'd5, OPC_LOAD, 32'hD000_0006);
        i_id  = make_src(5'd5, 5'd5, 1'b1, 1'b1);
        step();
        i_ex = make_stage(1'b0, 5'd0, OPC_LOAD, 32'hE000_0007);
        i_id = make_src(5'd0, 5'd0, 1'b1, 1'b1);
        step();

        // No forwarding for x0, unused sources or idle stages
        i_ex  = make_stage(1'b0, 5'd0, OPC_ALU, 32'hE000_0008);
        i_mem = make_stage(1'b0, 5'd0, OPC_ALU, 32'hD000_0008);
        step();
        i_ex = make_stage(1'b0, 5'd5, OPC_ALU, 32'hE000_0009);
        i_id = make_src(5'd5, 5'd7, 1'b0, 1'b1);
        step();
        i_ex  = make_stage(1'b1, 5'd5, OPC_LOAD, 32'hE000_000A);
        i_mem = make_stage(1'b1, 5'd7, OPC_ALU, 32'hD000_000A);
        i_id  = make_src(5'd5, 5'd7, 1'b1, 1'b1);
        step();

        // Mixed random traffic
        for (int k = 0; k < RANDOM_CYCLES; k++) begin
            i_id  = make_src(random_reg(), random_reg(), 1'($urandom), 1'($urandom));
            i_ex  = make_stage(($urandom % 3) == 0, random_reg(), op_class_e'($urandom % 6),
                               $urandom);
            i_mem = make_stage(($urandom % 3) == 0, random_reg(), op_class_e'($urandom % 6),
                               $urandom);
            i_wb  = make_wb(($urandom % 3) == 0, random_reg(), $urandom);
            step();
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
common/core_pkg.sv
verilog/rf32x32.sv
forward/data_forward_u.sv
verilog/id_data_picker.sv
verilog/id_operand_unit.sv
tests/tb_id_operand_unit.sv

/* verilog/id_data_picker.sv */
`default_nettype none

module id_data_picker (
    input  logic [core_pkg::XLEN-1:0] i_rd1_data,
    input  logic [core_pkg::XLEN-1:0] i_rd2_data,
    input  logic [core_pkg::XLEN-1:0] i_ex_data,
    input  logic [core_pkg::XLEN-1:0] i_mem_data,
    input  core_pkg::fwd_ctrl_t       i_fwd,
    output logic [core_pkg::XLEN-1:0] o_data1,
    output logic [core_pkg::XLEN-1:0] o_data2
);

    import core_pkg::*;

    // Three-way operand mux
    function automatic logic [XLEN-1:0] pick_operand(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] rf_data,
        input logic [XLEN-1:0] ex_data,
        input logic [XLEN-1:0] mem_data
    );
        logic [XLEN-1:0] val;
        case (sel)
            FWD_EX:  val = ex_data;
            FWD_MEM: val = mem_data;
            // Unused encoding falls back to the register file
            default: val = rf_data;
        endcase
        return val;
    endfunction

    always_comb begin
        o_data1 = pick_operand(i_fwd.sel1, i_rd1_data, i_ex_data, i_mem_data);
    end

    always_comb begin
        o_data2 = pick_operand(i_fwd.sel2, i_rd2_data, i_ex_data, i_mem_data);
    end

endmodule

`default_nettype wire

/* verilog/id_operand_unit.sv */
`default_nettype none

module id_operand_unit (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  core_pkg::id_src_t         i_id,
    input  core_pkg::stage_dst_t      i_ex,
    input  core_pkg::stage_dst_t      i_mem,
    input  core_pkg::wb_write_t       i_wb,
    output logic [core_pkg::XLEN-1:0] o_data1,
    output logic [core_pkg::XLEN-1:0] o_data2,
    output logic                      o_stall
);

    import core_pkg::*;

    logic [XLEN-1:0] rd1_data;
    logic [XLEN-1:0] rd2_data;
    fwd_ctrl_t       fwd_ctrl;

    // Register file
    rf32x32 regfile_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_rs1      (i_id.rs1),
        .i_rs2      (i_id.rs2),
        .i_wb       (i_wb),
        .o_rd1_data (rd1_data),
        .o_rd2_data (rd2_data)
    );

    // Forwarding and load-use stall
    data_forward_u data_forward_u_inst (
        .i_id    (i_id),
        .i_ex    (i_ex),
        .i_mem   (i_mem),
        .o_fwd   (fwd_ctrl),
        .o_stall (o_stall)
    );

    // Final operand values
    id_data_picker id_data_picker_inst (
        .i_rd1_data (rd1_data),
        .i_rd2_data (rd2_data),
        .i_ex_data  (i_ex.fwd_data),
        .i_mem_data (i_mem.fwd_data),
        .i_fwd      (fwd_ctrl),
        .o_data1    (o_data1),
        .o_data2    (o_data2)
    );

endmodule

`default_nettype wire

/* verilog/rf32x32.sv */
`default_nettype none

module rf32x32 (
    input  logic                           clk,
    input  logic                           i_rst_n,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [core_pkg::REG_ADDR_W-1:0] i_rs2,
    input  core_pkg::wb_write_t            i_wb,
    output logic [core_pkg::XLEN-1:0]      o_rd1_data,
    output logic [core_pkg::XLEN-1:0]      o_rd2_data
);

    import core_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:NUM_REGS-1];
    logic            wb_active;

    assign wb_active = !i_wb.wr_n && (i_wb.wr_addr != '0);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_active) begin
            regs[i_wb.wr_addr] <= i_wb.data;
        end
    end

    // Same-cycle write wins over the stored value
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wb_active && (addr == i_wb.wr_addr)) begin
            val = i_wb.data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        o_rd1_data = read_port(i_rs1);
    end

    always_comb begin
        o_rd2_data = read_port(i_rs2);
    end

endmodule

`default_nettype wire
